// File: Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = thread_manager_tb
FLIST = thread_manager.f
OBJ   = obj_dir
BIN   = $(OBJ)/V$(TOP)
SRCS  = $(shell grep -v '^+' $(FLIST))

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

clean:
	rm -rf $(OBJ)

// File: dv/thread_manager_chk.sv
`timescale 1ns/1ns

module thread_manager_chk #(
  parameter int PEND_DEPTH   = 8,
  parameter int ACT_SLOTS    = 8,
  parameter int SLICE_CYCLES = 6
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        cmd_valid_i,
  input  thrd_pkg::cmd_e              cmd_i,
  input  logic [thrd_pkg::ADDR_W-1:0] addr_i,
  input  logic [thrd_pkg::DATA_W-1:0] data_i,
  input  logic                        exp_ok_i,
  input  logic                        rslt_valid_i,
  input  logic                        rslt_ok_i,
  input  logic                        sched_valid_i,
  input  logic [thrd_pkg::ADDR_W-1:0] next_addr_i,
  input  logic [thrd_pkg::DATA_W-1:0] next_data_i,
  output int                          val_errs_o,
  output int                          misc_errs_o
);
  import thrd_pkg::*;

  // reference model of queue, table, timer and step flag
  thrd_entry_t pend_q[$];
  thrd_entry_t slot_ent [ACT_SLOTS];
  bit          slot_vld [ACT_SLOTS];
  bit          slot_stp [ACT_SLOTS];
  int          rr;
  int          cnt;
  bit          step_pend;
  bit          seen_rst = 1'b0;
  int          val_errs = 0;
  int          misc_errs = 0;
  // pulses expected at the next edge
  bit          exp_rv;
  bit          exp_ok;
  bit          exp_sv;
  thrd_entry_t exp_ent;

  assign val_errs_o  = val_errs;
  assign misc_errs_o = misc_errs;

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
    val_errs++;
  endtask

  // fork if possible, else rotate, else drop
  task automatic run_step();
    int free;
    int idx;
    bit any_vld;
    free    = -1;
    any_vld = 1'b0;
    for (int i = ACT_SLOTS - 1; i >= 0; i--) begin
      if (!slot_vld[i]) begin
        free = i;
      end
      any_vld |= slot_vld[i];
    end
    if (pend_q.size() > 0 && free >= 0) begin
      slot_ent[free] = pend_q.pop_front();
      slot_vld[free] = 1'b1;
      slot_stp[free] = 1'b0;
      rr             = free;
      exp_sv         = 1'b1;
      exp_ent        = slot_ent[free];
    end else if (any_vld) begin
      for (int i = 0; i < ACT_SLOTS; i++) begin
        if (slot_stp[i]) begin
          slot_vld[i] = 1'b0;
        end
        slot_stp[i] = 1'b0;
      end
      for (int k = 1; k <= ACT_SLOTS && !exp_sv; k++) begin
        idx = (rr + k) % ACT_SLOTS;
        if (slot_vld[idx]) begin
          rr      = idx;
          exp_sv  = 1'b1;
          exp_ent = slot_ent[idx];
        end
      end
    end
  endtask

  always @(posedge clk) begin
    bit          tick;
    bit          model_ok;
    thrd_entry_t ent;
    if (rst) begin
      if (seen_rst && (rslt_valid_i !== 1'b0 || sched_valid_i !== 1'b0)) begin
        $display("a result or schedule pulse appeared during reset at %0t", $time);
        misc_errs++;
      end
      seen_rst = 1'b1;
      pend_q.delete();
      for (int i = 0; i < ACT_SLOTS; i++) begin
        slot_vld[i] = 1'b0;
        slot_stp[i] = 1'b0;
      end
      rr        = 0;
      cnt       = 0;
      step_pend = 1'b0;
      exp_rv    = 1'b0;
      exp_sv    = 1'b0;
    end else begin
      // outputs seen now come from the previous edge
      if (sched_valid_i !== exp_sv) begin
        report_mismatch("sched_valid_o", 32'(exp_sv), 32'(sched_valid_i));
      end else if (exp_sv) begin
        if (next_addr_i !== exp_ent.addr) begin
          report_mismatch("next_addr_o", 32'(exp_ent.addr), 32'(next_addr_i));
        end
        if (next_data_i !== exp_ent.data) begin
          report_mismatch("next_data_o", exp_ent.data, next_data_i);
        end
      end
      if (rslt_valid_i !== exp_rv) begin
        report_mismatch("rslt_valid_o", 32'(exp_rv), 32'(rslt_valid_i));
      end else if (exp_rv && rslt_ok_i !== exp_ok) begin
        report_mismatch("rslt_ok_o", 32'(exp_ok), 32'(rslt_ok_i));
      end
      exp_rv = 1'b0;
      exp_sv = 1'b0;
      tick   = (cnt == 0);
      cnt    = tick ? SLICE_CYCLES - 1 : cnt - 1;
      if (cmd_valid_i) begin
        model_ok = 1'b0;
        if (cmd_i == CMD_RUN) begin
          model_ok = (pend_q.size() < PEND_DEPTH);
          ent.addr = addr_i;
          ent.data = data_i;
          if (model_ok) begin
            pend_q.push_back(ent);
          end
        end else if (cmd_i == CMD_STOP) begin
          for (int i = 0; i < ACT_SLOTS; i++) begin
            if (slot_vld[i] && slot_ent[i].addr == addr_i) begin
              slot_stp[i] = 1'b1;
              model_ok    = 1'b1;
            end
          end
        end
        if (model_ok != exp_ok_i) begin
          $display("tests file expects ok %0b at %0t but the model predicts %0b",
                   exp_ok_i, $time, model_ok);
          misc_errs++;
        end
        exp_rv = 1'b1;
        exp_ok = exp_ok_i;
        if (tick) begin
          step_pend = 1'b1;
        end
      end else if (step_pend) begin
        step_pend = 1'b0;
        run_step();
      end else if (tick) begin
        step_pend = 1'b1;
      end
    end
  end

endmodule

// File: dv/thread_manager_tb.sv
`timescale 1ns/1ns

module thread_manager_tb;
  import thrd_pkg::*;

  localparam int PEND_DEPTH   = 8;
  localparam int ACT_SLOTS    = 8;
  localparam int SLICE_CYCLES = 6;
  // a line flagged as random gets 0 to RAND_GAP-1 extra idle cycles
  localparam int RAND_GAP     = 16;

  typedef struct {
    int                gap;
    bit                rnd;
    cmd_e              cmd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    bit                ok;
  } test_line_t;

  logic              clk;
  logic              rst;
  logic              cmd_valid;
  cmd_e              cmd;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data;
  logic              exp_ok;
  logic              rslt_valid;
  logic              rslt_ok;
  logic              sched_valid;
  logic [ADDR_W-1:0] next_addr;
  logic [DATA_W-1:0] next_data;
  int                val_errs;
  int                misc_errs;
  int                load_errs = 0;
  int                limit_cycles = 0;
  integer            seed = 73;
  test_line_t        tests[$];

  always #2 clk = ~clk;

  thread_manager #(
    .PEND_DEPTH   (PEND_DEPTH),
    .ACT_SLOTS    (ACT_SLOTS),
    .SLICE_CYCLES (SLICE_CYCLES)
  ) DUT (
    .clk           (clk),
    .rst           (rst),
    .cmd_valid_i   (cmd_valid),
    .cmd_i         (cmd),
    .addr_i        (addr),
    .data_i        (data),
    .rslt_valid_o  (rslt_valid),
    .rslt_ok_o     (rslt_ok),
    .sched_valid_o (sched_valid),
    .next_addr_o   (next_addr),
    .next_data_o   (next_data)
  );

  thread_manager_chk #(
    .PEND_DEPTH   (PEND_DEPTH),
    .ACT_SLOTS    (ACT_SLOTS),
    .SLICE_CYCLES (SLICE_CYCLES)
  ) u_chk (
    .clk           (clk),
    .rst           (rst),
    .cmd_valid_i   (cmd_valid),
    .cmd_i         (cmd),
    .addr_i        (addr),
    .data_i        (data),
    .exp_ok_i      (exp_ok),
    .rslt_valid_i  (rslt_valid),
    .rslt_ok_i     (rslt_ok),
    .sched_valid_i (sched_valid),
    .next_addr_i   (next_addr),
    .next_data_i   (next_data),
    .val_errs_o    (val_errs),
    .misc_errs_o   (misc_errs)
  );

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_gap;
    logic [31:0] f_rnd;
    logic [31:0] f_cmd;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_ok;
    test_line_t  t;
    fd = $fopen("dv/thread_manager_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open the tests file dv/thread_manager_tests.txt");
      load_errs++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.substr(0, 0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%h %h %h %h %h %h", f_gap, f_rnd, f_cmd, f_addr, f_data, f_ok);
        if (n != 6) begin
          $display("malformed line in the tests file: %s", line);
          load_errs++;
        end else begin
          t.gap  = int'(f_gap);
          t.rnd  = f_rnd[0];
          t.cmd  = cmd_e'(f_cmd[1:0]);
          t.addr = f_addr[ADDR_W-1:0];
          t.data = f_data;
          t.ok   = f_ok[0];
          tests.push_back(t);
        end
      end
      $fclose(fd);
      if (tests.size() == 0) begin
        $display("the tests file holds no commands");
        load_errs++;
      end
    end
  endtask

  // one-cycle command strobe, driven just after the edge
  task automatic send_command(input test_line_t t);
    cmd_valid = 1'b1;
    cmd       = t.cmd;
    addr      = t.addr;
    data      = t.data;
    exp_ok    = t.ok;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    cmd       = CMD_NONE;
    exp_ok    = 1'b0;
  endtask

  initial begin
    int total;
    int idle;
    clk       = 1'b0;
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd       = CMD_NONE;
    addr      = '0;
    data      = '0;
    exp_ok    = 1'b0;
    load_tests();
    total = tests.size() + 50;
    foreach (tests[i]) begin
      total += tests[i].gap + (tests[i].rnd ? RAND_GAP : 0);
    end
    limit_cycles = total * SLICE_CYCLES;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    foreach (tests[i]) begin
      idle = tests[i].gap;
      if (tests[i].rnd) begin
        idle += {$random(seed)} % RAND_GAP;
      end
      repeat (idle) begin
        @(posedge clk);
        #1;
      end
      send_command(tests[i]);
    end
    // let the last pulses reach the checker
    repeat (3 * SLICE_CYCLES) @(posedge clk);
    $display("errors: %0d value mismatches, %0d other failures", val_errs,
             misc_errs + load_errs);
    if (val_errs == 0 && misc_errs == 0 && load_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the test sequence did not finish within %0d cycles", limit_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: dv/thread_manager_tests.txt
# gap: idle cycles before the command, rnd: 1 adds random idle cycles, cmd: 1 RUN 2 STOP
# all columns hex: gap rnd cmd addr data ok
02 0 1 0100 a0000000 1
00 0 1 0101 a0000001 1
00 0 1 0102 a0000002 1
00 0 1 0103 a0000003 1
00 0 1 0104 a0000004 1
00 0 1 0105 a0000005 1
00 0 1 0106 a0000006 1
00 0 1 0107 a0000007 1
00 0 1 0108 a0000008 0
40 1 2 0103 00000000 1
00 0 2 0999 00000000 0
20 1 2 0103 00000000 0
00 0 1 0200 b0000000 1
14 1 2 0200 00000000 1
00 0 2 0100 00000000 1
20 1 2 0200 00000000 0
20 1 2 0100 00000000 0
10 0 1 0300 c0000000 1

// File: hw/active_table.sv
`timescale 1ns/1ns

module active_table #(
  parameter int ACT_SLOTS = 8
) (
  input  logic                        clk,
  input  logic                        rst,
  thrd_op_if.tbl                      op,
  input  logic [thrd_pkg::ADDR_W-1:0] addr_i,
  input  thrd_pkg::thrd_entry_t       fork_entry_i,
  output logic                        sched_valid_o,
  output logic [thrd_pkg::ADDR_W-1:0] next_addr_o,
  output logic [thrd_pkg::DATA_W-1:0] next_data_o
);
  import thrd_pkg::*;

  localparam int SLOT_W = (ACT_SLOTS > 1) ? $clog2(ACT_SLOTS) : 1;

  thrd_entry_t          ent_q [ACT_SLOTS];
  logic [ACT_SLOTS-1:0] valid_q;
  logic [ACT_SLOTS-1:0] stop_q;
  logic [ACT_SLOTS-1:0] match;
  logic [ACT_SLOTS-1:0] live;
  logic [SLOT_W-1:0]    rr_q;
  logic [SLOT_W-1:0]    free_slot;
  logic [SLOT_W-1:0]    rot_slot;
  logic                 rot_found;

  // address compare against every valid slot
  always_comb begin
    for (int i = 0; i < ACT_SLOTS; i++) begin
      match[i] = valid_q[i] && (ent_q[i].addr == addr_i);
    end
  end

  assign op.stop_hit  = |match;
  assign op.act_valid = valid_q;

  // slots that survive the next rotate
  assign live = valid_q & ~stop_q;

  // downward scan so the lowest free slot wins
  always_comb begin
    free_slot = '0;
    for (int i = ACT_SLOTS - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_slot = SLOT_W'(i);
      end
    end
  end

  // next live slot after rr_q with the pointer itself checked last
  always_comb begin
    int idx;
    rot_found = 1'b0;
    rot_slot  = rr_q;
    for (int k = ACT_SLOTS; k >= 1; k--) begin
      idx = (int'(rr_q) + k) % ACT_SLOTS;
      if (live[idx]) begin
        rot_found = 1'b1;
        rot_slot  = SLOT_W'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q       <= '0;
      stop_q        <= '0;
      rr_q          <= '0;
      sched_valid_o <= 1'b0;
    end else begin
      sched_valid_o <= 1'b0;
      if (op.fork_req) begin
        valid_q[free_slot] <= 1'b1;
        stop_q[free_slot]  <= 1'b0;
        rr_q               <= free_slot;
        sched_valid_o      <= 1'b1;
      end else if (op.rotate) begin
        // stop-marked threads leave here
        valid_q <= live;
        stop_q  <= '0;
        if (rot_found) begin
          rr_q          <= rot_slot;
          sched_valid_o <= 1'b1;
        end
      end else if (op.stop_req) begin
        stop_q <= stop_q | match;
      end
    end
  end

  // slot payload and the reported thread
  always_ff @(posedge clk) begin
    if (op.fork_req) begin
      ent_q[free_slot] <= fork_entry_i;
      next_addr_o      <= fork_entry_i.addr;
      next_data_o      <= fork_entry_i.data;
    end else if (op.rotate) begin
      next_addr_o <= ent_q[rot_slot].addr;
      next_data_o <= ent_q[rot_slot].data;
    end
  end

  // a fork must land in an empty slot
  a_fork_free: assert property (@(posedge clk) disable iff (rst)
    op.fork_req |-> !valid_q[free_slot]);

endmodule

// File: hw/pending_queue.sv
`timescale 1ns/1ns

module pending_queue #(
  parameter int  PEND_DEPTH = 8,
  parameter type entry_t    = logic
) (
  input  logic     clk,
  input  logic     rst,
  thrd_op_if.queue op,
  input  entry_t   push_entry_i,
  output entry_t   head_o
);

  localparam int PTR_W = (PEND_DEPTH > 1) ? $clog2(PEND_DEPTH) : 1;
  localparam int CNT_W = $clog2(PEND_DEPTH + 1);

  entry_t           mem_q [PEND_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // pointer step with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(PEND_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign op.pend_full  = (count_q == CNT_W'(PEND_DEPTH));
  assign op.pend_empty = (count_q == '0);

  // oldest thread, read by the table on a fork
  assign head_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (op.push) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (op.push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (op.fork_req) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({op.push, op.fork_req})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    op.pend_full |-> !op.push);

endmodule

// File: hw/slice_timer.sv
`timescale 1ns/1ns

module slice_timer #(
  parameter int SLICE_CYCLES = 6
) (
  input  logic clk,
  input  logic rst,
  output logic tick_o
);

  localparam int CNT_W = (SLICE_CYCLES > 1) ? $clog2(SLICE_CYCLES) : 1;

  logic [CNT_W-1:0] cnt_q;

  // tick whenever the counter has run down
  assign tick_o = (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (tick_o) begin
      cnt_q <= CNT_W'(SLICE_CYCLES - 1);
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  a_tick_single: assert property (@(posedge clk) disable iff (rst)
    tick_o |=> !tick_o);

endmodule

// File: hw/thrd_ctl_fsm.sv
`timescale 1ns/1ns

module thrd_ctl_fsm (
  input  logic           clk,
  input  logic           rst,
  input  logic           cmd_valid_i,
  input  thrd_pkg::cmd_e cmd_i,
  input  logic           tick_i,
  thrd_op_if.fsm         op,
  output logic           rslt_valid_o,
  output logic           rslt_ok_o
);
  import thrd_pkg::*;

  fsm_state_e state_d;
  fsm_state_e state_q;
  logic       step_pend_q;
  logic       rslt_ok_d;

  // a command always wins over a pending step
  always_comb begin
    if (cmd_valid_i) begin
      state_d = ST_CMD;
    end else if (step_pend_q) begin
      state_d = ST_STEP;
    end else begin
      state_d = ST_IDLE;
    end
  end

  // command decode
  assign op.push     = (state_d == ST_CMD) && (cmd_i == CMD_RUN) && !op.pend_full;
  assign op.stop_req = (state_d == ST_CMD) && (cmd_i == CMD_STOP);

  // fork before rotate before dropping the step
  assign op.fork_req = (state_d == ST_STEP) && !op.pend_empty && !op.act_full;
  assign op.rotate   = (state_d == ST_STEP) && !op.fork_req && !op.act_empty;

  always_comb begin
    case (cmd_i)
      CMD_RUN:  rslt_ok_d = !op.pend_full;
      CMD_STOP: rslt_ok_d = op.stop_hit;
      default:  rslt_ok_d = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ST_IDLE;
      step_pend_q <= 1'b0;
      rslt_ok_o   <= 1'b0;
    end else begin
      state_q <= state_d;
      // a tick during the step cycle folds into that step
      if (state_d == ST_STEP) begin
        step_pend_q <= 1'b0;
      end else if (tick_i) begin
        step_pend_q <= 1'b1;
      end
      if (state_d == ST_CMD) begin
        rslt_ok_o <= rslt_ok_d;
      end
    end
  end

  // result pulse one cycle after the command strobe
  assign rslt_valid_o = (state_q == ST_CMD);

  a_one_op: assert property (@(posedge clk) disable iff (rst)
    $onehot0({op.push, op.stop_req, op.fork_req, op.rotate}));

  a_fork_not_empty: assert property (@(posedge clk) disable iff (rst)
    op.fork_req |-> !op.pend_empty);

endmodule

// File: hw/thrd_op_if.sv
`timescale 1ns/1ns

interface thrd_op_if #(
  parameter int ACT_SLOTS = 8
);

  // operation strobes from the FSM
  logic push;
  logic stop_req;
  logic fork_req;
  logic rotate;

  // queue status
  logic pend_full;
  logic pend_empty;

  // table status
  logic [ACT_SLOTS-1:0] act_valid;
  logic                 act_full;
  logic                 act_empty;
  logic                 stop_hit;

  // occupancy reduced from the slot valid bits
  assign act_full  = &act_valid;
  assign act_empty = ~|act_valid;

  modport fsm (
    output push, stop_req, fork_req, rotate,
    input  pend_full, pend_empty, act_full, act_empty, stop_hit
  );

  modport queue (
    input  push, fork_req,
    output pend_full, pend_empty
  );

  modport tbl (
    input  stop_req, fork_req, rotate,
    output act_valid, stop_hit
  );

endinterface

// File: hw/thrd_pkg.sv
package thrd_pkg;

  // thread start address and data word
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // host command codes
  typedef enum logic [1:0] {
    CMD_NONE = 2'd0,
    CMD_RUN  = 2'd1,
    CMD_STOP = 2'd2
  } cmd_e;

  // one thread as it sits in the pending queue and the active table
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } thrd_entry_t;

  // control FSM states
  // ST_CMD   command sampled this cycle
  // ST_STEP  scheduling step taken this cycle
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_STEP = 2'd1,
    ST_CMD  = 2'd2
  } fsm_state_e;

endpackage

// File: hw/thread_manager.sv
`timescale 1ns/1ns

module thread_manager #(
  parameter int PEND_DEPTH   = 8,
  parameter int ACT_SLOTS    = 8,
  parameter int SLICE_CYCLES = 6
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        cmd_valid_i,
  input  thrd_pkg::cmd_e              cmd_i,
  input  logic [thrd_pkg::ADDR_W-1:0] addr_i,
  input  logic [thrd_pkg::DATA_W-1:0] data_i,
  output logic                        rslt_valid_o,
  output logic                        rslt_ok_o,
  output logic                        sched_valid_o,
  output logic [thrd_pkg::ADDR_W-1:0] next_addr_o,
  output logic [thrd_pkg::DATA_W-1:0] next_data_o
);
  import thrd_pkg::*;

  thrd_entry_t run_entry;
  thrd_entry_t head_entry;
  logic        tick;

  thrd_op_if #(.ACT_SLOTS(ACT_SLOTS)) op_if ();

  // a RUN command queues address and data together
  assign run_entry = '{addr: addr_i, data: data_i};

  slice_timer #(
    .SLICE_CYCLES(SLICE_CYCLES)
  ) u_timer (
    .clk    (clk),
    .rst    (rst),
    .tick_o (tick)
  );

  thrd_ctl_fsm u_fsm (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .tick_i       (tick),
    .op           (op_if.fsm),
    .rslt_valid_o (rslt_valid_o),
    .rslt_ok_o    (rslt_ok_o)
  );

  pending_queue #(
    .PEND_DEPTH (PEND_DEPTH),
    .entry_t    (thrd_entry_t)
  ) u_queue (
    .clk          (clk),
    .rst          (rst),
    .op           (op_if.queue),
    .push_entry_i (run_entry),
    .head_o       (head_entry)
  );

  active_table #(
    .ACT_SLOTS(ACT_SLOTS)
  ) u_table (
    .clk           (clk),
    .rst           (rst),
    .op            (op_if.tbl),
    .addr_i        (addr_i),
    .fork_entry_i  (head_entry),
    .sched_valid_o (sched_valid_o),
    .next_addr_o   (next_addr_o),
    .next_data_o   (next_data_o)
  );

endmodule

// File: thread_manager.f
hw/thrd_pkg.sv
hw/thrd_op_if.sv
hw/thrd_ctl_fsm.sv
hw/slice_timer.sv
hw/pending_queue.sv
hw/active_table.sv
hw/thread_manager.sv
dv/thread_manager_chk.sv
dv/thread_manager_tb.sv
